/* Bender.yml */
package:
  name: texture_lod

sources:
  - include_dirs:
      - include
    files:
      - hw/lod_pkg.sv
      - hw/lod_cfg_pkg.sv
      - hw/lod_rho.sv
      - hw/log2_table.sv
      - hw/lod_clamp.sv
      - hw/lod_regs.sv
      - hw/texture_lod.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/texture_lod_sva.sv
      - dv/texture_lod_tb.sv

/* dv/texture_lod_sva.sv */
`timescale 1ns/100ps
`include "lod_defs.svh"

module texture_lod_sva (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  in_valid,
	input lod_pkg::lod_deriv_t   deriv,
	input logic                  cfg_we,
	input logic                  cfg_re,
	input lod_cfg_pkg::lod_reg_e cfg_addr,
	input logic [7:0]            cfg_wdata,
	input logic [7:0]            cfg_rdata,
	input logic                  out_valid,
	input lod_pkg::mip_sel_t     mip
);
	import lod_pkg::*;
	import lod_cfg_pkg::*;

	int         error_count = 0;
	lod_cfg_t   m_cfg;
	logic [7:0] exp_rdata;
	logic       v1;
	logic       v2;
	logic       v3;
	int         s1_rho;
	lod_log2_t  s2_log;
	mip_sel_t   s3_mip;

	// largest magnitude of the four, 8 fraction bits.
	function automatic int footprint(input lod_deriv_t d);
		logic [`LOD_DERIV_W-1:0] w [4];
		int m;
		int v;
		w = '{d.dudx, d.dvdx, d.dudy, d.dvdy};
		m = 0;
		foreach (w[i]) begin
			v = $signed(w[i]);
			v = (v < 0) ? -v : v;
			m = (v > m) ? v : m;
		end
		return m;
	endfunction

	function automatic lod_log2_t table_lookup(input int rho, input bit trilinear);
		int lvl;
		lvl = 0;
		if (rho >= (1 << 18)) begin
			lvl = `LOD_MAX_LEVEL; // overflow.
		end else begin
			for (int n = 1; n <= 8; n++) begin
				if (rho >= (3 << (n + 6))) begin
					lvl = n;
				end
			end
			if (trilinear && rho[lvl + 8]) begin
				lvl++;
			end
		end
		return '{level: 4'(lvl), fract: 6'(rho >> (lvl + 2))};
	endfunction

	function automatic mip_sel_t select_mip(input lod_log2_t t, input lod_cfg_t c);
		int  lvl;
		int  sel;
		int  lo;
		int  hi;
		bit  clamped;
		bit  blend;
		lvl     = int'(t.level) + int'($signed(c.bias));
		lo      = int'(c.min_level);
		hi      = int'(c.max_level);
		clamped = (lvl < 0) || (lvl > `LOD_MAX_LEVEL);
		lvl     = (lvl < 0) ? 0 : (lvl > `LOD_MAX_LEVEL) ? `LOD_MAX_LEVEL : lvl;
		if (lo > hi || lvl < lo) begin
			sel = lo;
		end else begin
			sel = (lvl > hi) ? hi : lvl;
		end
		clamped = clamped || (sel != lvl);
		blend   = (c.filter == filt_trilinear) && !clamped;
		return '{level: 4'(sel), fract: (blend ? t.fract : 6'd0), blend: blend};
	endfunction

	function automatic logic [7:0] read_field(input lod_reg_e a, input lod_cfg_t c);
		case (a)
			reg_mode: return {7'd0, c.filter};
			reg_bias: return {4'd0, c.bias};
			reg_min:  return {4'd0, c.min_level};
			default:  return {4'd0, c.max_level};
		endcase
	endfunction

	// ########################################
	// reference pipeline

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_cfg     <= '{filter: filt_bilinear, bias: 4'sd0, min_level: 4'd0,
			              max_level: 4'(`LOD_MAX_LEVEL)};
			exp_rdata <= 8'd0;
			v1        <= 1'b0;
			v2        <= 1'b0;
			v3        <= 1'b0;
		end else begin
			v1 <= in_valid;
			v2 <= v1;
			v3 <= v2;
			if (in_valid) s1_rho <= footprint(deriv);
			if (v1) s2_log <= table_lookup(s1_rho, m_cfg.filter == filt_trilinear);
			if (v2) s3_mip <= select_mip(s2_log, m_cfg);
			if (cfg_re) exp_rdata <= read_field(cfg_addr, m_cfg);
			if (cfg_we) begin
				case (cfg_addr)
					reg_mode: m_cfg.filter    <= lod_filter_e'(cfg_wdata[0]);
					reg_bias: m_cfg.bias      <= cfg_wdata[3:0];
					reg_min:  m_cfg.min_level <= cfg_wdata[3:0];
					default:  m_cfg.max_level <= cfg_wdata[3:0];
				endcase
			end
		end
	end

	// ########################################
	// checks

	a_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == v3)
		else begin
			$error("FAILED out_valid got %h expected %h", $sampled(out_valid), $sampled(v3));
			error_count++;
		end

	a_mip: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> mip == s3_mip)
		else begin
			$error("FAILED mip level/fract/blend got %h/%h/%h expected %h/%h/%h",
			       $sampled(mip.level), $sampled(mip.fract), $sampled(mip.blend),
			       $sampled(s3_mip.level), $sampled(s3_mip.fract), $sampled(s3_mip.blend));
			error_count++;
		end

	a_rdata: assert property (@(posedge clk) disable iff (!rst_n) cfg_rdata == exp_rdata)
		else begin
			$error("FAILED cfg_rdata got %h expected %h",
			       $sampled(cfg_rdata), $sampled(exp_rdata));
			error_count++;
		end

endmodule

bind texture_lod texture_lod_sva u_sva (.*);

/* dv/texture_lod_tb.sv */
`timescale 1ns/100ps
`include "lod_defs.svh"

module texture_lod_tb;
	import lod_pkg::*;
	import lod_cfg_pkg::*;

	localparam int clk_period    = 100;
	localparam int drive_delay   = 10;
	localparam int n_rand        = 64;
	localparam int stim_cycles   = 230 + 2 * n_rand; // length of the sequence below.
	localparam int margin_cycles = 50;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	lod_deriv_t deriv;
	logic       cfg_we;
	logic       cfg_re;
	lod_reg_e   cfg_addr;
	logic [7:0] cfg_wdata;
	logic [7:0] cfg_rdata;
	logic       out_valid;
	mip_sel_t   mip;
	integer     seed;
	logic [7:0] limits [3] = '{8'h26, 8'h53, 8'h90}; // min, max nibbles.

	texture_lod dut (.*);

	always #(clk_period / 2) clk = ~clk;

	task automatic next_cycle();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic write_reg(input lod_reg_e addr, input logic [7:0] data);
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		next_cycle();
		cfg_we    = 1'b0;
	endtask

	task automatic read_regs();
		for (int a = 0; a < 4; a++) begin
			cfg_re   = 1'b1;
			cfg_addr = lod_reg_e'(a);
			next_cycle();
			cfg_re   = 1'b0;
			next_cycle(); // rdata holds here.
		end
	endtask

	task automatic send_deriv(input lod_deriv_t d);
		in_valid = 1'b1;
		deriv    = d;
		next_cycle();
		in_valid = 1'b0;
	endtask

	// mag in one slot with random sign, smaller values elsewhere.
	task automatic send_footprint(input int mag, input int slot);
		logic [`LOD_DERIV_W-1:0] w [4];
		for (int i = 0; i < 4; i++) begin
			w[i] = $random(seed) % (mag + 1);
		end
		w[slot] = ($random(seed) & 1) ? -mag : mag;
		send_deriv({w[0], w[1], w[2], w[3]});
	endtask

	task automatic send_random();
		logic [`LOD_DERIV_W-1:0] w [4];
		for (int i = 0; i < 4; i++) begin
			w[i] = $random(seed) >>> (8 + ($random(seed) & 15));
		end
		send_deriv({w[0], w[1], w[2], w[3]});
	endtask

	task automatic sweep_thresholds();
		int extra_vals [6] = '{0, 256, (1 << 18) - 1, 1 << 18, 8388607, 8388608};
		for (int n = 1; n <= 8; n++) begin
			send_footprint(3 << (n + 6), n % 4);
			send_footprint((3 << (n + 6)) - 1, (n + 1) % 4);
			send_footprint(1 << (n + 8), (n + 2) % 4);
			send_footprint((1 << (n + 8)) - 1, (n + 3) % 4);
		end
		foreach (extra_vals[i]) send_footprint(extra_vals[i], i % 4);
	endtask

	task automatic drain();
		repeat (4) next_cycle(); // three stages plus one.
	endtask

	always @(posedge clk) begin
		if (dut.u_sva.error_count != 0) begin
			$display("Done: errors found");
			$fatal(1, "assertion failure in the bound checker");
		end
	end

	initial begin
		#((stim_cycles + margin_cycles) * clk_period);
		$display("Done: errors found");
		$fatal(1, "timeout, the stimulus did not finish");
	end

	initial begin
		seed      = 41534;
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		deriv     = '0;
		cfg_we    = 1'b0;
		cfg_re    = 1'b0;
		cfg_addr  = reg_mode;
		cfg_wdata = 8'd0;
		repeat (3) @(posedge clk);
		#drive_delay;
		rst_n = 1'b1;
		read_regs();
		write_reg(reg_mode, 8'h01);
		write_reg(reg_bias, 8'h0d);
		write_reg(reg_min, 8'h02);
		write_reg(reg_max, 8'h07);
		read_regs();

		// ########################################
		// bilinear then trilinear, back to back
		write_reg(reg_mode, 8'h00);
		write_reg(reg_bias, 8'h00);
		write_reg(reg_min, 8'h00);
		write_reg(reg_max, 8'h09);
		sweep_thresholds();
		repeat (n_rand) send_random();
		drain();
		write_reg(reg_mode, 8'h01);
		sweep_thresholds();
		repeat (n_rand) send_random();
		drain();

		// ########################################
		// bias and clamp
		for (int b = -8; b < 8; b++) begin
			write_reg(reg_bias, 8'(b));
			send_footprint(0, b & 3);
			send_footprint(1 << 17, (b + 1) & 3);
			repeat (2) send_random();
		end
		write_reg(reg_bias, 8'h00);
		foreach (limits[i]) begin
			write_reg(reg_min, {4'd0, limits[i][7:4]});
			write_reg(reg_max, {4'd0, limits[i][3:0]});
			repeat (6) send_random();
		end
		drain();

		if (dut.u_sva.error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "assertion failures in the bound checker");
		end
	end

endmodule

/* hw/lod_cfg_pkg.sv */
`include "lod_defs.svh"

package lod_cfg_pkg;

	typedef enum logic [`LOD_ADDR_W-1:0] {
		reg_mode = 2'd0,
		reg_bias = 2'd1,
		reg_min  = 2'd2,
		reg_max  = 2'd3
	} lod_reg_e;

	typedef enum logic {
		filt_bilinear  = 1'b0,
		filt_trilinear = 1'b1
	} lod_filter_e;

	typedef struct packed {
		lod_filter_e       filter;
		logic signed [3:0] bias; // in whole levels.
		logic [3:0]        min_level;
		logic [3:0]        max_level;
	} lod_cfg_t;

endpackage

/* hw/lod_clamp.sv */
`timescale 1ns/100ps
`include "lod_defs.svh"

module lod_clamp (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  lod_pkg::lod_log2_t     log2,
	input  lod_cfg_pkg::lod_cfg_t  cfg,
	output logic                   out_valid,
	output lod_pkg::mip_sel_t      mip
);
	import lod_cfg_pkg::*;

	logic signed [5:0] biased;
	logic [3:0]        sat_level;
	logic              sat_hit;
	logic [3:0]        final_level;
	logic              clamp_hit;
	logic              blend;

	assign biased = $signed({2'b00, log2.level}) + $signed({{2{cfg.bias[3]}}, cfg.bias});

	// ########################################
	// saturate then clamp

	always_comb begin
		sat_hit   = 1'b1;
		sat_level = 4'd0;
		if (biased < 6'sd0) begin
			sat_level = 4'd0;
		end else if (biased > `LOD_MAX_LEVEL) begin
			sat_level = 4'(`LOD_MAX_LEVEL);
		end else begin
			sat_level = biased[3:0];
			sat_hit   = 1'b0;
		end
	end

	// min applied last so it wins over max.
	always_comb begin
		final_level = sat_level;
		if (final_level > cfg.max_level) begin
			final_level = cfg.max_level;
		end
		if (final_level < cfg.min_level) begin
			final_level = cfg.min_level;
		end
		clamp_hit = sat_hit || (final_level != sat_level);
	end

	assign blend = (cfg.filter == filt_trilinear) && !clamp_hit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mip.level <= final_level;
			mip.fract <= blend ? log2.fract : 6'd0; // single level otherwise.
			mip.blend <= blend;
		end
	end

endmodule

/* hw/lod_pkg.sv */
`include "lod_defs.svh"

package lod_pkg;

	// ########################################
	// datapath bundles

	typedef struct packed {
		logic signed [`LOD_DERIV_W-1:0] dudx;
		logic signed [`LOD_DERIV_W-1:0] dvdx;
		logic signed [`LOD_DERIV_W-1:0] dudy;
		logic signed [`LOD_DERIV_W-1:0] dvdy;
	} lod_deriv_t;

	typedef struct packed {
		logic [3:0] level;
		logic [5:0] fract; // blend weight toward next level.
	} lod_log2_t;

	typedef struct packed {
		logic [3:0] level;
		logic [5:0] fract;
		logic       blend; // two levels to be blended.
	} mip_sel_t;

endpackage

/* hw/lod_regs.sv */
`timescale 1ns/100ps
`include "lod_defs.svh"

module lod_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   we,
	input  logic                   re,
	input  lod_cfg_pkg::lod_reg_e  addr,
	input  logic [7:0]             wdata,
	output logic [7:0]             rdata,
	output lod_cfg_pkg::lod_cfg_t  cfg
);
	import lod_cfg_pkg::*;

	logic [7:0] rd_mux;

	// ########################################
	// write decode

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.filter    <= filt_bilinear;
			cfg.bias      <= 4'sd0;
			cfg.min_level <= 4'd0;
			cfg.max_level <= 4'(`LOD_MAX_LEVEL); // full range.
		end else if (we) begin
			case (addr)
				reg_mode: cfg.filter    <= lod_filter_e'(wdata[0]);
				reg_bias: cfg.bias      <= $signed(wdata[3:0]);
				reg_min:  cfg.min_level <= wdata[3:0];
				reg_max:  cfg.max_level <= wdata[3:0];
			endcase
		end
	end

	// ########################################
	// read back

	always_comb begin
		case (addr)
			reg_mode: rd_mux = {7'd0, cfg.filter};
			reg_bias: rd_mux = {4'd0, cfg.bias}; // raw two's complement.
			reg_min:  rd_mux = {4'd0, cfg.min_level};
			reg_max:  rd_mux = {4'd0, cfg.max_level};
			default:  rd_mux = 8'd0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= 8'd0;
		end else if (re) begin
			rdata <= rd_mux; // holds until next read.
		end
	end

endmodule

/* hw/lod_rho.sv */
`timescale 1ns/100ps
`include "lod_defs.svh"

module lod_rho (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  lod_pkg::lod_deriv_t   deriv,
	output logic                  rho_valid,
	output logic [`LOD_VAL_W-1:0] rho
);

	logic [`LOD_DERIV_W-1:0] abs_dudx;
	logic [`LOD_DERIV_W-1:0] abs_dvdx;
	logic [`LOD_DERIV_W-1:0] abs_dudy;
	logic [`LOD_DERIV_W-1:0] abs_dvdy;
	logic [`LOD_DERIV_W-1:0] max_x;
	logic [`LOD_DERIV_W-1:0] max_y;
	logic [`LOD_DERIV_W-1:0] max_all;

	// most negative input maps to 2^23 unsigned.
	function automatic logic [`LOD_DERIV_W-1:0] mag(
		input logic signed [`LOD_DERIV_W-1:0] d
	);
		return d[`LOD_DERIV_W-1] ? -d : d;
	endfunction

	assign abs_dudx = mag(deriv.dudx);
	assign abs_dvdx = mag(deriv.dvdx);
	assign abs_dudy = mag(deriv.dudy);
	assign abs_dvdy = mag(deriv.dvdy);

	assign max_x   = (abs_dudx > abs_dvdx) ? abs_dudx : abs_dvdx; // x direction.
	assign max_y   = (abs_dudy > abs_dvdy) ? abs_dudy : abs_dvdy; // y direction.
	assign max_all = (max_x > max_y) ? max_x : max_y;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rho_valid <= 1'b0;
		end else begin
			rho_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			rho <= {{(`LOD_VAL_W - `LOD_DERIV_W){1'b0}}, max_all};
		end
	end

endmodule

/* hw/log2_table.sv */
`timescale 1ns/100ps
`include "lod_defs.svh"

module log2_table (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic                  trilinear_en,
	input  logic [`LOD_VAL_W-1:0] val,
	output logic                  out_valid,
	output lod_pkg::lod_log2_t    log2
);

	logic [9:0] log_in;
	logic       over_flow;
	logic [3:0] base_level;
	logic [3:0] int_mm_no;
	logic [5:0] lod_fract;

	assign log_in    = val[17:8];
	assign over_flow = |val[`LOD_VAL_W-1:18];

	// ########################################
	// priority table

	// level n starts at 3 << (n+6). val[7] resolves the level 1 edge.
	always_comb begin
		casez ({over_flow, log_in, val[7]})
			12'b1_??????????_?: base_level = 4'(`LOD_MAX_LEVEL);
			12'b0_1?????????_?,
			12'b0_01????????_?,
			12'b0_0011??????_?: base_level = 4'd8;
			12'b0_0010??????_?,
			12'b0_00011?????_?: base_level = 4'd7;
			12'b0_00010?????_?,
			12'b0_000011????_?: base_level = 4'd6;
			12'b0_000010????_?,
			12'b0_0000011???_?: base_level = 4'd5;
			12'b0_0000010???_?,
			12'b0_00000011??_?: base_level = 4'd4;
			12'b0_00000010??_?,
			12'b0_000000011?_?: base_level = 4'd3;
			12'b0_000000010?_?,
			12'b0_0000000011_?: base_level = 4'd2;
			12'b0_0000000010_?,
			12'b0_0000000001_1: base_level = 4'd1;
			default:            base_level = 4'd0;
		endcase
	end

	// ########################################
	// trilinear raise and fraction

	always_comb begin
		int_mm_no = base_level;
		// upper half of the bracket.
		if (trilinear_en && !over_flow && log_in[base_level]) begin
			int_mm_no = base_level + 4'd1;
		end
		lod_fract = val[int_mm_no + 2 +: 6]; // bits level+7 down to level+2.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			log2.level <= int_mm_no;
			log2.fract <= lod_fract;
		end
	end

endmodule

/* hw/texture_lod.sv */
`timescale 1ns/100ps
`include "lod_defs.svh"

module texture_lod (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  lod_pkg::lod_deriv_t    deriv,
	input  logic                   cfg_we,
	input  logic                   cfg_re,
	input  lod_cfg_pkg::lod_reg_e  cfg_addr,
	input  logic [7:0]             cfg_wdata,
	output logic [7:0]             cfg_rdata,
	output logic                   out_valid,
	output lod_pkg::mip_sel_t      mip
);
	import lod_pkg::*;
	import lod_cfg_pkg::*;

	lod_cfg_t              cfg;
	logic                  rho_valid;
	logic [`LOD_VAL_W-1:0] rho;
	logic                  log_valid;
	lod_log2_t             log2;

	lod_regs u_regs (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (cfg_we),
		.re    (cfg_re),
		.addr  (cfg_addr),
		.wdata (cfg_wdata),
		.rdata (cfg_rdata),
		.cfg   (cfg)
	);

	// ########################################
	// three stage datapath

	lod_rho u_rho (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.deriv     (deriv),
		.rho_valid (rho_valid),
		.rho       (rho)
	);

	log2_table u_log2 (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (rho_valid),
		.trilinear_en (cfg.filter == filt_trilinear),
		.val          (rho),
		.out_valid    (log_valid),
		.log2         (log2)
	);

	lod_clamp u_clamp (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (log_valid),
		.log2      (log2),
		.cfg       (cfg),
		.out_valid (out_valid),
		.mip       (mip)
	);

endmodule

/* include/lod_defs.svh */
`ifndef LOD_DEFS_SVH
`define LOD_DEFS_SVH

// signed 16.8 texel derivative.
`define LOD_DERIV_W 24
// footprint word, 8 fraction bits.
`define LOD_VAL_W 32
`define LOD_MAX_LEVEL 9
`define LOD_ADDR_W 2

`endif

/* texture_lod.f */
+incdir+include
hw/lod_pkg.sv
hw/lod_cfg_pkg.sv
hw/lod_rho.sv
hw/log2_table.sv
hw/lod_clamp.sv
hw/lod_regs.sv
hw/texture_lod.sv
dv/texture_lod_sva.sv
dv/texture_lod_tb.sv
